// ==== Bender.yml ====
package:
  name: ooo_exec

sources:
  - target: rtl
    include_dirs:
      - source
    files:
      - source/exec_types_pkg.sv
      - source/wb_bus_pkg.sv
      - source/issue_queue.sv
      - source/alu_unit.sv
      - source/mul_unit.sv
      - source/div_unit.sv
      - source/wb_arbiter.sv
      - source/exec_cluster.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/exec_cluster_assertions.sv
      - verification/exec_cluster_tb.sv

// ==== ooo_exec.f ====
+incdir+source
source/exec_types_pkg.sv
source/wb_bus_pkg.sv
source/issue_queue.sv
source/alu_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/exec_cluster.sv
verification/exec_cluster_assertions.sv
verification/exec_cluster_tb.sv

// ==== source/alu_unit.sv ====
`include "exec_cfg.svh"

module alu_unit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          push,
   input  exec_types_pkg::exec_payload_t push_data,
   output logic                          credit,
   output logic                          wb_req,
   output exec_types_pkg::result_t       wb_result,
   input  logic                          grant
);
   import exec_types_pkg::*;

   exec_payload_t                  head;
   logic                           not_empty;
   logic                           pop;
   logic                           hold_valid;
   result_t                        hold;
   data_t                          alu_out;
   logic [$clog2(`EXEC_XLEN)-1:0]  shamt;

   issue_queue #(.payload_type(exec_payload_t), .depth(`EXEC_QUEUE_DEPTH)) u_queue (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head      (head),
      .not_empty (not_empty),
      .credit    (credit)
   );

   assign pop   = !hold_valid || grant;   // hold register frees up this cycle
   assign shamt = head.b[$clog2(`EXEC_XLEN)-1:0];   // only low bits count

   always_comb begin
      case (head.op)
         op_sub:  alu_out = head.a - head.b;
         op_and:  alu_out = head.a & head.b;
         op_or:   alu_out = head.a | head.b;
         op_xor:  alu_out = head.a ^ head.b;
         op_slt:  alu_out = data_t'($signed(head.a) < $signed(head.b));
         op_sltu: alu_out = data_t'(head.a < head.b);
         op_sll:  alu_out = head.a << shamt;
         op_srl:  alu_out = head.a >> shamt;
         op_sra:  alu_out = data_t'($signed(head.a) >>> shamt);
         default: alu_out = head.a + head.b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_valid <= 1'b0;
      end else if (pop) begin
         hold_valid <= not_empty;
      end
   end

   always_ff @(posedge clk) begin
      if (pop && not_empty) begin
         hold <= '{tag: head.tag, data: alu_out};
      end
   end

   assign wb_req    = hold_valid;
   assign wb_result = hold;

endmodule

// ==== source/div_unit.sv ====
`include "exec_cfg.svh"

module div_unit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          push,
   input  exec_types_pkg::exec_payload_t push_data,
   output logic                          credit,
   output logic                          wb_req,
   output exec_types_pkg::result_t       wb_result,
   input  logic                          grant
);
   import exec_types_pkg::*;

   localparam int    xlen    = `EXEC_XLEN;
   localparam int    cnt_w   = $clog2(xlen + 1);
   localparam data_t min_int = {1'b1, {(xlen-1){1'b0}}};

   typedef enum logic [1:0] {div_idle, div_busy, div_done} div_state_t;

   exec_payload_t    head;
   logic             not_empty;
   div_state_t       state;
   logic [cnt_w-1:0] count;
   logic             is_signed;
   logic             sign_a;
   logic             sign_b;
   data_t            quo;
   data_t            rem;
   data_t            divisor;
   data_t            dividend;
   tag_t             tag;
   logic             want_rem;
   logic             neg_q;
   logic             neg_r;
   logic             div_zero;
   logic             signed_ovf;
   logic [xlen:0]    rem_shift;
   logic [xlen:0]    trial;
   data_t            q_fix;
   data_t            r_fix;

   issue_queue #(.payload_type(exec_payload_t), .depth(`EXEC_QUEUE_DEPTH)) u_queue (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (state == div_idle),
      .head      (head),
      .not_empty (not_empty),
      .credit    (credit)
   );

   assign is_signed = (head.op == op_div) || (head.op == op_rem);
   assign sign_a    = is_signed && head.a[xlen-1];
   assign sign_b    = is_signed && head.b[xlen-1];

   // one restoring step, the dividend shifts out of quo as quotient bits shift in
   assign rem_shift = {rem, quo[xlen-1]};
   assign trial     = rem_shift - {1'b0, divisor};

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= div_idle;
         count <= '0;
      end else begin
         case (state)
            div_idle: begin
               if (not_empty) begin
                  state <= div_busy;
                  count <= cnt_w'(xlen);
               end
            end
            div_busy: begin
               count <= count - 1'b1;
               if (count == cnt_w'(1)) begin
                  state <= div_done;
               end
            end
            div_done: begin
               if (grant) begin
                  state <= div_idle;
               end
            end
            default: state <= div_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == div_idle) && not_empty) begin
         tag        <= head.tag;
         dividend   <= head.a;
         quo        <= sign_a ? -head.a : head.a;   // magnitudes only
         divisor    <= sign_b ? -head.b : head.b;
         rem        <= '0;
         want_rem   <= (head.op == op_rem) || (head.op == op_remu);
         neg_q      <= sign_a ^ sign_b;
         neg_r      <= sign_a;   // remainder takes the dividend sign
         div_zero   <= (head.b == '0);
         signed_ovf <= is_signed && (head.a == min_int) && (head.b == '1);
      end else if (state == div_busy) begin
         if (!trial[xlen]) begin
            rem <= trial[xlen-1:0];
            quo <= {quo[xlen-2:0], 1'b1};
         end else begin
            rem <= rem_shift[xlen-1:0];
            quo <= {quo[xlen-2:0], 1'b0};
         end
      end
   end

   always_comb begin
      q_fix = neg_q ? -quo : quo;
      r_fix = neg_r ? -rem : rem;
      if (div_zero) begin
         q_fix = '1;
         r_fix = dividend;
      end else if (signed_ovf) begin
         q_fix = dividend;
         r_fix = '0;
      end
   end

   assign wb_req    = (state == div_done);
   assign wb_result = '{tag: tag, data: want_rem ? r_fix : q_fix};

endmodule

// ==== source/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath widths
`define EXEC_XLEN 32
`define EXEC_TAG_W 6

// issue queue entries per unit, also the starting credit count
`define EXEC_QUEUE_DEPTH 4

// multiplier pop to result latency
`define EXEC_MUL_STAGES 3

// ALU, multiplier, divider
`define EXEC_NUM_UNITS 3

`endif

// ==== source/exec_cluster.sv ====
`include "exec_cfg.svh"

module exec_cluster (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       dispatch_valid,
   input  exec_types_pkg::exec_op_t   dispatch_op,
   input  exec_types_pkg::tag_t       dispatch_tag,
   input  exec_types_pkg::data_t      dispatch_a,
   input  exec_types_pkg::data_t      dispatch_b,
   output logic [`EXEC_NUM_UNITS-1:0] credit_return,
   output logic                       wb_valid,
   output exec_types_pkg::tag_t       wb_tag,
   output exec_types_pkg::data_t      wb_data
);
   import exec_types_pkg::*;
   import wb_bus_pkg::*;

   exec_payload_t               payload;
   unit_id_t                    target;
   logic [`EXEC_NUM_UNITS-1:0]  push;
   logic [`EXEC_NUM_UNITS-1:0]  req;
   result_t                     results [`EXEC_NUM_UNITS];
   grant_t                      grant;

   assign payload = '{op: dispatch_op, tag: dispatch_tag, a: dispatch_a, b: dispatch_b};

   always_comb begin
      case (dispatch_op[4:3])
         2'b01:   target = unit_mul;
         2'b10:   target = unit_div;
         default: target = unit_alu;   // 00 and the 11 shift group
      endcase
      push         = '0;
      push[target] = dispatch_valid;
   end

   alu_unit u_alu (
      .clk       (clk),
      .reset     (reset),
      .push      (push[unit_alu]),
      .push_data (payload),
      .credit    (credit_return[unit_alu]),
      .wb_req    (req[unit_alu]),
      .wb_result (results[unit_alu]),
      .grant     (grant[unit_alu])
   );

   mul_unit u_mul (
      .clk       (clk),
      .reset     (reset),
      .push      (push[unit_mul]),
      .push_data (payload),
      .credit    (credit_return[unit_mul]),
      .wb_req    (req[unit_mul]),
      .wb_result (results[unit_mul]),
      .grant     (grant[unit_mul])
   );

   div_unit u_div (
      .clk       (clk),
      .reset     (reset),
      .push      (push[unit_div]),
      .push_data (payload),
      .credit    (credit_return[unit_div]),
      .wb_req    (req[unit_div]),
      .wb_result (results[unit_div]),
      .grant     (grant[unit_div])
   );

   wb_arbiter u_arbiter (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .results  (results),
      .grant    (grant),
      .wb_valid (wb_valid),
      .wb_tag   (wb_tag),
      .wb_data  (wb_data)
   );

endmodule

// ==== source/exec_types_pkg.sv ====
`include "exec_cfg.svh"

package exec_types_pkg;

   typedef logic [`EXEC_XLEN-1:0] data_t;
   typedef logic [`EXEC_TAG_W-1:0] tag_t;

   // op[4:3] selects the unit: 00 ALU, 01 MUL, 10 DIV, 11 ALU shifts
   typedef enum logic [4:0] {
      op_add    = 5'b00_000,
      op_sub    = 5'b00_001,
      op_and    = 5'b00_010,
      op_or     = 5'b00_011,
      op_xor    = 5'b00_100,
      op_slt    = 5'b00_101,
      op_sltu   = 5'b00_110,
      op_mul    = 5'b01_000,
      op_mulh   = 5'b01_001,
      op_mulhsu = 5'b01_010,
      op_mulhu  = 5'b01_011,
      op_div    = 5'b10_000,
      op_divu   = 5'b10_001,
      op_rem    = 5'b10_010,
      op_remu   = 5'b10_011,
      op_sll    = 5'b11_000,
      op_srl    = 5'b11_001,
      op_sra    = 5'b11_010
   } exec_op_t;

   typedef struct packed {
      exec_op_t op;
      tag_t     tag;
      data_t    a;
      data_t    b;
   } exec_payload_t;

   typedef struct packed {
      tag_t  tag;
      data_t data;
   } result_t;

endpackage

// ==== source/issue_queue.sv ====
`include "exec_cfg.svh"

module issue_queue #(
   parameter type payload_type = logic,
   parameter int  depth        = `EXEC_QUEUE_DEPTH
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        push,
   input  payload_type push_data,
   input  logic        pop,
   output payload_type head,
   output logic        not_empty,
   output logic        credit
);
   localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = idx_w + 1;

   payload_type      entries [depth];
   logic [idx_w-1:0] wr_idx;
   logic [idx_w-1:0] rd_idx;
   logic [cnt_w-1:0] count;
   logic             do_pop;

   assign not_empty = (count != '0);
   assign do_pop    = pop && not_empty;
   assign credit    = do_pop;   // one credit per entry leaving
   assign head      = entries[rd_idx];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_idx <= '0;
         rd_idx <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_idx <= (wr_idx == idx_w'(depth - 1)) ? '0 : wr_idx + 1'b1;
         end
         if (do_pop) begin
            rd_idx <= (rd_idx == idx_w'(depth - 1)) ? '0 : rd_idx + 1'b1;
         end
         count <= count + cnt_w'(push) - cnt_w'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_idx] <= push_data;
      end
   end

endmodule

// ==== source/mul_unit.sv ====
`include "exec_cfg.svh"

module mul_unit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          push,
   input  exec_types_pkg::exec_payload_t push_data,
   output logic                          credit,
   output logic                          wb_req,
   output exec_types_pkg::result_t       wb_result,
   input  logic                          grant
);
   import exec_types_pkg::*;

   localparam int xlen = `EXEC_XLEN;
   localparam int pw   = 2 * xlen;
   localparam int n    = `EXEC_MUL_STAGES - 1;   // the output buffer is the last stage

   exec_payload_t   head;
   logic            not_empty;
   logic            advance;
   logic            a_signed;
   logic            b_signed;
   logic [pw+1:0]   full_prod;
   logic [n-1:0]    stage_valid;
   exec_op_t        stage_op [n];
   tag_t            stage_tag [n];
   logic [pw-1:0]   stage_prod [n];
   data_t           last_data;
   result_t         out_buf [2];
   logic [1:0]      buf_count;
   logic            buf_push;
   logic            wr_slot;

   issue_queue #(.payload_type(exec_payload_t), .depth(`EXEC_QUEUE_DEPTH)) u_queue (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (advance),
      .head      (head),
      .not_empty (not_empty),
      .credit    (credit)
   );

   assign advance  = (buf_count != 2'd2) || grant;   // stall only on a full buffer
   assign a_signed = (head.op == op_mulh) || (head.op == op_mulhsu);
   assign b_signed = (head.op == op_mulh);

   // 33 bit operands cover all four sign combinations
   assign full_prod = $signed({a_signed & head.a[xlen-1], head.a}) *
                      $signed({b_signed & head.b[xlen-1], head.b});

   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= '0;
      end else if (advance) begin
         stage_valid[0] <= not_empty;
         for (int i = 1; i < n; i++) begin
            stage_valid[i] <= stage_valid[i-1];
         end
      end
   end

   // later stages only delay the product, leaving room to retime the multiplier
   always_ff @(posedge clk) begin
      if (advance) begin
         stage_op[0]   <= head.op;
         stage_tag[0]  <= head.tag;
         stage_prod[0] <= full_prod[pw-1:0];
         for (int i = 1; i < n; i++) begin
            stage_op[i]   <= stage_op[i-1];
            stage_tag[i]  <= stage_tag[i-1];
            stage_prod[i] <= stage_prod[i-1];
         end
      end
   end

   assign last_data = (stage_op[n-1] == op_mul) ? stage_prod[n-1][xlen-1:0]
                                                : stage_prod[n-1][pw-1:xlen];

   assign buf_push = advance && stage_valid[n-1];
   assign wr_slot  = (buf_count == 2'd2) || ((buf_count == 2'd1) && !grant);

   always_ff @(posedge clk) begin
      if (reset) begin
         buf_count <= '0;
      end else begin
         buf_count <= buf_count + 2'(buf_push) - 2'(grant);
      end
   end

   always_ff @(posedge clk) begin
      if (grant) begin
         out_buf[0] <= out_buf[1];   // shift toward the bus
      end
      if (buf_push) begin
         out_buf[wr_slot] <= '{tag: stage_tag[n-1], data: last_data};
      end
   end

   assign wb_req    = (buf_count != '0);
   assign wb_result = out_buf[0];

endmodule

// ==== source/wb_arbiter.sv ====
`include "exec_cfg.svh"

module wb_arbiter (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`EXEC_NUM_UNITS-1:0] req,
   input  exec_types_pkg::result_t    results [`EXEC_NUM_UNITS],
   output wb_bus_pkg::grant_t         grant,
   output logic                       wb_valid,
   output exec_types_pkg::tag_t       wb_tag,
   output exec_types_pkg::data_t      wb_data
);
   import wb_bus_pkg::*;

   localparam int n = `EXEC_NUM_UNITS;

   unit_id_t last_grant;
   unit_id_t pick;
   logic     found;

   // search starts one past the last winner
   always_comb begin
      int idx;
      grant = '0;
      pick  = last_grant;
      found = 1'b0;
      for (int i = 1; i <= n; i++) begin
         idx = (int'(last_grant) + i) % n;
         if (!found && req[idx]) begin
            found = 1'b1;
            pick  = unit_id_t'(idx);
         end
      end
      grant[pick] = found;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_valid   <= 1'b0;
         last_grant <= unit_id_t'(n - 1);   // ALU wins first
      end else begin
         wb_valid <= found;
         if (found) begin
            last_grant <= pick;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (found) begin
         wb_tag  <= results[pick].tag;
         wb_data <= results[pick].data;
      end
   end

endmodule

// ==== source/wb_bus_pkg.sv ====
`include "exec_cfg.svh"

package wb_bus_pkg;

   typedef logic [1:0] unit_id_t;
   typedef logic [`EXEC_NUM_UNITS-1:0] grant_t;

   // requester slots on the writeback bus
   localparam unit_id_t unit_alu = 2'd0;
   localparam unit_id_t unit_mul = 2'd1;
   localparam unit_id_t unit_div = 2'd2;

endpackage

// ==== verification/exec_cluster_assertions.sv ====
`include "exec_cfg.svh"

module exec_cluster_assertions (
   input logic                       clk,
   input logic                       reset,
   input logic                       dispatch_valid,
   input exec_types_pkg::exec_op_t   dispatch_op,
   input exec_types_pkg::tag_t       dispatch_tag,
   input exec_types_pkg::data_t      dispatch_a,
   input exec_types_pkg::data_t      dispatch_b,
   input logic [`EXEC_NUM_UNITS-1:0] credit_return,
   input logic                       wb_valid,
   input exec_types_pkg::tag_t       wb_tag,
   input exec_types_pkg::data_t      wb_data
);
   timeunit 1ns;
   timeprecision 100ps;
   import exec_types_pkg::*;

   localparam int xlen    = `EXEC_XLEN;
   localparam int n_units = `EXEC_NUM_UNITS;
   localparam int depth   = `EXEC_QUEUE_DEPTH;
   localparam int n_tags  = 2 ** `EXEC_TAG_W;

   data_t             exp_data [n_tags];
   logic [n_tags-1:0] pending;
   int                credits [n_units];
   int                credits_next [n_units];
   int                disp_cls;
   string             test_name = "";   // set by the testbench as each test starts
   int                fail_count = 0;   // read by the testbench at each test end

   // unit class from the top two opcode bits
   function automatic int class_of(exec_op_t op);
      case (op[4:3])
         2'b01:   return 1;
         2'b10:   return 2;
         default: return 0;   // ALU and the 11 shift group
      endcase
   endfunction

   // RV32IM reference results
   function automatic data_t expected_result(exec_op_t op, data_t a, data_t b);
      logic signed [2*xlen-1:0] sa;
      logic signed [2*xlen-1:0] sb;
      logic [2*xlen-1:0]        ua;
      logic [2*xlen-1:0]        ub;
      logic [2*xlen-1:0]        prod;
      logic                     ovf;
      data_t                    r;
      sa   = {{xlen{a[xlen-1]}}, a};
      sb   = {{xlen{b[xlen-1]}}, b};
      ua   = {{xlen{1'b0}}, a};
      ub   = {{xlen{1'b0}}, b};
      prod = '0;
      ovf  = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
      case (op)
         op_add:    r = a + b;
         op_sub:    r = a - b;
         op_and:    r = a & b;
         op_or:     r = a | b;
         op_xor:    r = a ^ b;
         op_slt:    r = ($signed(a) < $signed(b)) ? 1 : 0;
         op_sltu:   r = (a < b) ? 1 : 0;
         op_sll:    r = a << b[4:0];
         op_srl:    r = a >> b[4:0];
         op_sra:    r = $signed(a) >>> b[4:0];
         op_mul: begin
            prod = ua * ub;
            r    = prod[xlen-1:0];
         end
         op_mulh: begin
            prod = sa * sb;
            r    = prod[2*xlen-1:xlen];
         end
         op_mulhsu: begin
            prod = sa * ub;   // low 64 bits are sign-correct
            r    = prod[2*xlen-1:xlen];
         end
         op_mulhu: begin
            prod = ua * ub;
            r    = prod[2*xlen-1:xlen];
         end
         op_div:    r = (b == '0) ? '1 : (ovf ? a : data_t'($signed(a) / $signed(b)));
         op_divu:   r = (b == '0) ? '1 : a / b;
         op_rem:    r = (b == '0) ? a : (ovf ? '0 : data_t'($signed(a) % $signed(b)));
         op_remu:   r = (b == '0) ? a : a % b;
         default:   r = '0;
      endcase
      return r;
   endfunction

   assign disp_cls = class_of(dispatch_op);

   always_comb begin
      for (int c = 0; c < n_units; c++) begin
         credits_next[c] = credits[c] + int'(credit_return[c])
                           - ((dispatch_valid && disp_cls == c) ? 1 : 0);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= '0;
         for (int c = 0; c < n_units; c++) begin
            credits[c] <= depth;
         end
      end else begin
         for (int c = 0; c < n_units; c++) begin
            credits[c] <= credits_next[c];
         end
         if (wb_valid) begin
            pending[wb_tag] <= 1'b0;
         end
         if (dispatch_valid) begin   // a reused tag wins over its old clear
            pending[dispatch_tag]  <= 1'b1;
            exp_data[dispatch_tag] <= expected_result(dispatch_op, dispatch_a, dispatch_b);
         end
      end
   end

   a_wb_value: assert property (@(posedge clk) disable iff (reset)
      wb_valid |-> (wb_data == exp_data[wb_tag]))
   else begin
      $error("FAILED %s tag %0d expected %h actual %h", test_name,
             $sampled(wb_tag), $sampled(exp_data[wb_tag]), $sampled(wb_data));
      fail_count++;
   end

   a_wb_once: assert property (@(posedge clk) disable iff (reset)
      wb_valid |-> pending[wb_tag])
   else begin
      $error("tag %0d written back without an outstanding dispatch", $sampled(wb_tag));
      fail_count++;
   end

   a_dispatch_credit: assert property (@(posedge clk) disable iff (reset)
      dispatch_valid |-> (credits[disp_cls] > 0))
   else begin
      $error("dispatch to unit %0d without a credit", $sampled(disp_cls));
      fail_count++;
   end

   for (genvar c = 0; c < n_units; c++) begin : g_credit_limit
      a_credit_max: assert property (@(posedge clk) disable iff (reset)
         credits_next[c] <= depth)
      else begin
         $error("unit %0d returned more credits than its queue holds", c);
         fail_count++;
      end
   end

   // outputs are clear from the second reset edge on
   a_quiet_reset: assert property (@(posedge clk)
      (reset && $past(reset)) |-> (credit_return == '0 && !wb_valid))
   else begin
      $error("credit return or writeback while reset is asserted");
      fail_count++;
   end

endmodule

bind exec_cluster exec_cluster_assertions u_checks (
   .clk            (clk),
   .reset          (reset),
   .dispatch_valid (dispatch_valid),
   .dispatch_op    (dispatch_op),
   .dispatch_tag   (dispatch_tag),
   .dispatch_a     (dispatch_a),
   .dispatch_b     (dispatch_b),
   .credit_return  (credit_return),
   .wb_valid       (wb_valid),
   .wb_tag         (wb_tag),
   .wb_data        (wb_data)
);

// ==== verification/exec_cluster_tb.sv ====
`include "exec_cfg.svh"

module exec_cluster_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import exec_types_pkg::*;

   localparam int  n_units     = `EXEC_NUM_UNITS;
   localparam int  depth       = `EXEC_QUEUE_DEPTH;
   localparam int  n_tags      = 2 ** `EXEC_TAG_W;
   localparam time drive_delay = 10ns;
   localparam int  drain_limit = 1000;
   // five tests of up to 64 divides at 34 cycles each plus margin
   localparam int  max_cycles  = 20000;

   logic               clk;
   logic               reset;
   logic               dispatch_valid;
   exec_op_t           dispatch_op;
   tag_t               dispatch_tag;
   data_t              dispatch_a;
   data_t              dispatch_b;
   logic [n_units-1:0] credit_return;
   logic               wb_valid;
   tag_t               wb_tag;
   data_t              wb_data;

   int                 credits [n_units];
   int                 returned [n_units];
   logic [n_tags-1:0]  pending;
   int                 outstanding;
   tag_t               next_tag;
   int                 cycle_count;
   int                 tests_passed;
   int                 tests_failed;
   int                 checks_before;

   exec_op_t alu_list [10] = '{op_add, op_sub, op_and, op_or, op_xor,
                               op_sll, op_srl, op_sra, op_slt, op_sltu};
   exec_op_t mul_list [4]  = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
   exec_op_t div_list [4]  = '{op_div, op_divu, op_rem, op_remu};

   exec_cluster UUT (
      .clk            (clk),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch_op    (dispatch_op),
      .dispatch_tag   (dispatch_tag),
      .dispatch_a     (dispatch_a),
      .dispatch_b     (dispatch_b),
      .credit_return  (credit_return),
      .wb_valid       (wb_valid),
      .wb_tag         (wb_tag),
      .wb_data        (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         $display("run stopped after %0d cycles without finishing", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

   // outputs settle after the rising edge, so look at them mid-cycle
   always @(negedge clk) begin
      for (int c = 0; c < n_units; c++) begin
         if (credit_return[c] === 1'b1) begin
            credits[c]++;
            returned[c]++;
         end
      end
      if (wb_valid === 1'b1 && pending[wb_tag]) begin
         pending[wb_tag] = 1'b0;
         outstanding--;
      end
   end

   function automatic int unit_of(exec_op_t op);
      case (op[4:3])
         2'b01:   return 1;
         2'b10:   return 2;
         default: return 0;   // ALU incl. shift group
      endcase
   endfunction

   function automatic bit all_credits_home();
      for (int c = 0; c < n_units; c++) begin
         if (credits[c] != depth) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #drive_delay;
   endtask

   task automatic apply_reset();
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      repeat (10) @(posedge clk);
      #drive_delay;
      reset       = 1'b0;
      pending     = '0;
      outstanding = 0;
      for (int c = 0; c < n_units; c++) begin
         credits[c] = depth;
      end
   endtask

   // waits for a credit of the op's class, then dispatches for one cycle
   task automatic send(input exec_op_t op, input data_t a, input data_t b);
      int cls;
      cls = unit_of(op);
      while (credits[cls] == 0) begin
         dispatch_valid = 1'b0;
         next_cycle();
      end
      while (pending[next_tag]) begin
         next_tag++;   // skip tags still in flight
      end
      dispatch_valid        = 1'b1;
      dispatch_op           = op;
      dispatch_tag          = next_tag;
      dispatch_a            = a;
      dispatch_b            = b;
      pending[next_tag]     = 1'b1;
      credits[cls]--;
      outstanding++;
      next_tag++;
      next_cycle();
      dispatch_valid = 1'b0;
   endtask

   // depth operations per class, back to back
   task automatic fill_queues();
      for (int i = 0; i < depth; i++) begin
         send(div_list[i], $urandom, $urandom);
         send(mul_list[i], $urandom, $urandom);
         send(alu_list[i], $urandom, $urandom);
      end
   endtask

   task automatic start_test(input string name);
      UUT.u_checks.test_name = name;
      checks_before = UUT.u_checks.fail_count;
      for (int c = 0; c < n_units; c++) begin
         returned[c] = 0;
      end
   endtask

   task automatic end_test(input string name, input bit check_returns);
      int waited;
      int new_fails;
      bit counts_ok;
      dispatch_valid = 1'b0;
      waited         = 0;
      while (waited < drain_limit && (outstanding != 0 || !all_credits_home())) begin
         next_cycle();
         waited++;
      end
      counts_ok = 1'b1;
      if (check_returns) begin
         for (int c = 0; c < n_units; c++) begin
            if (returned[c] != depth) begin
               $display("FAILED %s unit %0d expected %0d actual %0d credits returned",
                        name, c, depth, returned[c]);
               counts_ok = 1'b0;
            end
         end
      end
      new_fails = UUT.u_checks.fail_count - checks_before;
      if (outstanding != 0) begin
         $display("%s: failed, %0d results missing", name, outstanding);
         tests_failed++;
      end else if (!all_credits_home()) begin
         $display("%s: failed, credits not restored", name);
         tests_failed++;
      end else if (!counts_ok) begin
         $display("%s: failed, wrong number of credits returned", name);
         tests_failed++;
      end else if (new_fails != 0) begin
         $display("%s: failed, %0d result or protocol checks did not hold", name, new_fails);
         tests_failed++;
      end else begin
         $display("%s: passed", name);
         tests_passed++;
      end
   endtask

   initial begin
      data_t a;
      data_t b;
      int    cls;
      void'($urandom(32'hec18));
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      dispatch_op    = op_add;
      dispatch_tag   = '0;
      dispatch_a     = '0;
      dispatch_b     = '0;
      pending        = '0;
      outstanding    = 0;
      next_tag       = '0;
      cycle_count    = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      for (int c = 0; c < n_units; c++) begin
         credits[c]  = depth;
         returned[c] = 0;
      end
      apply_reset();

      start_test("alu_ops");
      send(op_slt, 32'hffff_ffff, 32'h0000_0001);   // signed -1 < 1
      send(op_sltu, 32'hffff_ffff, 32'h0000_0001);
      send(op_sll, 32'h0000_0001, 32'hffff_ffe4);   // upper shift bits ignored
      send(op_sra, 32'h8000_0000, 32'h0000_003f);
      send(op_srl, 32'h8000_0000, 32'h0000_0021);
      repeat (40) send(alu_list[$urandom_range(9)], $urandom, $urandom);
      end_test("alu_ops", 1'b0);

      start_test("mul_stream");
      for (int i = 0; i < 32; i++) begin
         send(mul_list[i % 4], $urandom, $urandom);
      end
      send(op_mulh, 32'h8000_0000, 32'h8000_0000);
      send(op_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
      send(op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
      end_test("mul_stream", 1'b0);

      start_test("div_ops");
      send(op_div, 32'h1234_5678, 32'h0);
      send(op_divu, 32'h1234_5678, 32'h0);
      send(op_rem, 32'h8765_4321, 32'h0);
      send(op_remu, 32'h8765_4321, 32'h0);
      send(op_div, 32'h8000_0000, 32'hffff_ffff);   // signed overflow case
      send(op_rem, 32'h8000_0000, 32'hffff_ffff);
      send(op_divu, 32'h8000_0000, 32'hffff_ffff);
      for (int i = 0; i < 16; i++) begin
         a = $urandom;
         b = $urandom >> $urandom_range(31);   // spread of divisor sizes
         send(div_list[i % 4], a, b);
      end
      end_test("div_ops", 1'b0);

      start_test("mixed_stream");
      for (int i = 0; i < 64; i++) begin
         cls = $urandom_range(2);
         a   = $urandom;
         b   = $urandom;
         case (cls)
            1:       send(mul_list[$urandom_range(3)], a, b);
            2:       send(div_list[$urandom_range(3)], a, b >> $urandom_range(31));
            default: send(alu_list[$urandom_range(9)], a, b);
         endcase
      end
      end_test("mixed_stream", 1'b0);

      fill_queues();
      apply_reset();   // divider still busy with queued work behind it
      start_test("credit_burst");
      fill_queues();
      end_test("credit_burst", 1'b1);

      $display("%0d tests passed, %0d tests failed, %0d assertion failures",
               tests_passed, tests_failed, UUT.u_checks.fail_count);
      if (tests_failed == 0 && UUT.u_checks.fail_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
